// ==== list.f ====
qspi_pkg.sv
qspi_txn_if.sv
qspi_controller.sv
wb_qspi_bridge.sv
qspi_subsys.sv
tb_qspi_mem.sv
tb_qspi_assert.sv
tb_qspi.sv

// ==== qspi_controller.sv ====
/* QSPI controller with command, address, dummy and data phases,
   read delay setting and RAM reselect spacing */
`timescale 1ns/1ns

module qspi_controller
   import qspi_pkg::*;
(
   input  logic       clk,
   input  logic       rstn,
   input  logic [3:0] spi_data_in,
   qspi_txn_if.ctrl   txn,
   output logic [3:0] spi_data_out,
   output logic [3:0] spi_data_oe,
   output logic       spi_clk_out,
   output logic       spi_flash_select,
   output logic       spi_ram_a_select,
   output logic       spi_ram_b_select
);

   typedef enum logic [2:0] {
      st_idle,
      st_cmd,
      st_addr,
      st_dummy,
      st_data
   } state_t;

   state_t                   state;
   logic                     is_writing;
   logic [2:0]               nib_left;
   logic [dev_addr_bits-1:0] addr_sr;
   logic [byte_bits-1:0]     data_sr;
   logic [byte_bits-1:0]     cmd_byte;
   logic [2:0]               delay_cfg;
   logic [2:0]               read_cnt;
   logic                     step;
   logic                     stop_pend;
   logic                     stop_now;
   logic                     is_ram;
   logic [1:0]               ram_req;
   logic [1:0]               ram_hold;
   logic [1:0]               ram_sel_n;
   logic [1:0]               gap_cnt [2];
   logic                     accept;

   // Top address bits pick the device
   assign is_ram   = txn.addr >= ram_a_base;
   assign ram_req  = {txn.addr >= ram_b_base, is_ram && (txn.addr < ram_b_base)};
   assign ram_hold = {gap_cnt[1] != 2'd0, gap_cnt[0] != 2'd0};
   assign accept   = (txn.start_read || txn.start_write) && !(|(ram_req & ram_hold));

   assign txn.busy  = state != st_idle;
   assign txn.rdata = data_sr;

   // A write stopped in the low clock phase finishes its nibble first
   assign stop_now = stop_pend || (txn.stop && !(is_writing && !spi_clk_out));

   // Reads advance on the delayed sample strobe and everything else on clock high
   assign step = (state == st_data && !is_writing) ? (read_cnt == 3'd0) : spi_clk_out;

   assign cmd_byte = is_writing ? cmd_quad_write : cmd_quad_read;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         stop_pend <= 1'b0;
      end else begin
         stop_pend <= txn.stop && is_writing && !spi_clk_out;
      end
   end

   // Delay setting is sampled from the data pins while in reset
   always_ff @(posedge clk) begin
      if (!rstn) begin
         delay_cfg <= spi_data_in[2:0];
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn || stop_now) begin
         state            <= st_idle;
         is_writing       <= 1'b0;
         nib_left         <= 3'd0;
         read_cnt         <= 3'd0;
         txn.data_ready   <= 1'b0;
         txn.data_req     <= 1'b0;
         spi_clk_out      <= 1'b1;
         spi_data_oe      <= 4'b0000;
         spi_flash_select <= 1'b1;
         spi_ram_a_select <= 1'b1;
         spi_ram_b_select <= 1'b1;
      end else begin
         txn.data_ready <= 1'b0;
         txn.data_req   <= 1'b0;
         if (state == st_idle) begin
            if (accept) begin
               state            <= st_cmd;
               // Flash only takes reads
               is_writing       <= txn.start_write && is_ram;
               nib_left         <= 3'd7;
               spi_data_oe      <= 4'b0001;
               spi_clk_out      <= 1'b0;
               spi_flash_select <= is_ram;
               spi_ram_a_select <= !ram_req[0];
               spi_ram_b_select <= !ram_req[1];
            end
         end else begin
            spi_clk_out <= !spi_clk_out;
            read_cnt    <= (read_cnt == 3'd0) ? 3'd1 : read_cnt - 3'd1;
            if (step) begin
               if (nib_left != 3'd0) begin
                  nib_left <= nib_left - 3'd1;
                  // Mode nibbles sent so the memory may drive next
                  if (state == st_dummy && nib_left == 3'(dummy_nibbles_read - 2)) begin
                     spi_data_oe <= 4'b0000;
                  end
                  // Ask for the next byte one cycle before it is loaded
                  if (state == st_data) begin
                     txn.data_req <= is_writing;
                  end
               end else begin
                  case (state)
                     st_cmd: begin
                        state       <= st_addr;
                        nib_left    <= 3'(dev_addr_bits / 4 - 1);
                        spi_data_oe <= 4'b1111;
                     end
                     st_addr: begin
                        if (is_writing) begin
                           state    <= st_data;
                           nib_left <= 3'(byte_bits / 4 - 1);
                        end else begin
                           state    <= st_dummy;
                           nib_left <= 3'(dummy_nibbles_read - 1);
                        end
                     end
                     st_dummy: begin
                        state    <= st_data;
                        nib_left <= 3'(byte_bits / 4 - 1);
                        read_cnt <= delay_cfg;
                     end
                     default: begin
                        nib_left       <= 3'(byte_bits / 4 - 1);
                        txn.data_ready <= !is_writing;
                     end
                  endcase
               end
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (state == st_idle && accept) begin
         addr_sr <= txn.addr[dev_addr_bits-1:0];
      end else if (state == st_addr && spi_clk_out) begin
         addr_sr <= {addr_sr[dev_addr_bits-5:0], 4'b0000};
      end
   end

   // Shifts out write nibbles and collects read nibbles
   always_ff @(posedge clk) begin
      if (is_writing) begin
         if (spi_clk_out && (state == st_addr || state == st_data)) begin
            if (nib_left == 3'd0) begin
               data_sr <= txn.wdata;
            end else if (state == st_data) begin
               data_sr <= {data_sr[byte_bits-5:0], 4'b0000};
            end
         end
      end else if (state == st_data && read_cnt == 3'd0) begin
         data_sr <= {data_sr[byte_bits-5:0], spi_data_in};
      end
   end

   always_comb begin
      case (state)
         st_cmd:  spi_data_out = {3'b000, cmd_byte[nib_left]};
         st_addr: spi_data_out = addr_sr[dev_addr_bits-1:dev_addr_bits-4];
         st_data: spi_data_out = data_sr[byte_bits-1:byte_bits-4];
         default: spi_data_out = 4'b1111;
      endcase
   end

   // Each RAM stays deselected for reselect_gap cycles after a transfer
   assign ram_sel_n = {spi_ram_b_select, spi_ram_a_select};

   always_ff @(posedge clk) begin
      if (!rstn) begin
         gap_cnt[0] <= 2'd0;
         gap_cnt[1] <= 2'd0;
      end else begin
         for (int i = 0; i < 2; i++) begin
            if (!ram_sel_n[i]) begin
               gap_cnt[i] <= 2'(reselect_gap - 1);
            end else if (gap_cnt[i] != 2'd0) begin
               gap_cnt[i] <= gap_cnt[i] - 2'd1;
            end
         end
      end
   end

endmodule

// ==== qspi_pkg.sv ====
/* Address map, QSPI command bytes, widths and timing constants
   shared by the QSPI memory subsystem */

package qspi_pkg;

   // Byte address across flash and both RAMs
   localparam int addr_bits = 25;

   // Address bits sent on the QSPI bus
   localparam int dev_addr_bits = 24;

   // One transaction byte and one bus word
   localparam int byte_bits = 8;
   localparam int word_bytes = 4;

   // Quad I/O command bytes sent serially on IO0
   localparam logic [byte_bits-1:0] cmd_quad_read = 8'hEB;
   localparam logic [byte_bits-1:0] cmd_quad_write = 8'h38;

   // Two mode nibbles followed by four dummy nibbles
   localparam int dummy_nibbles_read = 6;

   // Region bases with flash starting at zero
   localparam logic [addr_bits-1:0] ram_a_base = 25'h100_0000;
   localparam logic [addr_bits-1:0] ram_b_base = 25'h180_0000;

   // Minimum idle cycles before the same RAM is selected again
   localparam int reselect_gap = 2;

endpackage

// ==== qspi_subsys.sv ====
/* QSPI memory subsystem top with the Wishbone bridge and the QSPI
   controller */
`timescale 1ns/1ns

module qspi_subsys
   import qspi_pkg::*;
(
   input  logic                            clk,
   input  logic                            rstn,

   // Wishbone classic slave
   input  logic                            wb_cyc,
   input  logic                            wb_stb,
   input  logic                            wb_we,
   input  logic [addr_bits-1:0]            wb_adr,
   input  logic [word_bytes*byte_bits-1:0] wb_dat_w,
   output logic [word_bytes*byte_bits-1:0] wb_dat_r,
   output logic                            wb_ack,

   // Shared QSPI bus with three selects
   input  logic [3:0]                      spi_data_in,
   output logic [3:0]                      spi_data_out,
   output logic [3:0]                      spi_data_oe,
   output logic                            spi_clk_out,
   output logic                            spi_flash_select,
   output logic                            spi_ram_a_select,
   output logic                            spi_ram_b_select
);

   qspi_txn_if txn ();

   wb_qspi_bridge u_bridge (
      .clk      (clk),
      .rstn     (rstn),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_w (wb_dat_w),
      .wb_dat_r (wb_dat_r),
      .wb_ack   (wb_ack),
      .txn      (txn.host)
   );

   qspi_controller u_ctrl (
      .clk              (clk),
      .rstn             (rstn),
      .spi_data_in      (spi_data_in),
      .txn              (txn.ctrl),
      .spi_data_out     (spi_data_out),
      .spi_data_oe      (spi_data_oe),
      .spi_clk_out      (spi_clk_out),
      .spi_flash_select (spi_flash_select),
      .spi_ram_a_select (spi_ram_a_select),
      .spi_ram_b_select (spi_ram_b_select)
   );

endmodule

// ==== qspi_txn_if.sv ====
/* Byte transaction interface between the Wishbone bridge and the
   QSPI controller */
`timescale 1ns/1ns

interface qspi_txn_if
   import qspi_pkg::*;
();

   // Driven by the bridge
   logic [addr_bits-1:0] addr;
   logic [byte_bits-1:0] wdata;
   logic                 start_read;
   logic                 start_write;
   logic                 stop;

   // Driven by the controller
   logic [byte_bits-1:0] rdata;
   logic                 data_ready;
   logic                 data_req;
   logic                 busy;

   modport host (output addr, wdata, start_read, start_write, stop,
                 input rdata, data_ready, data_req, busy);

   modport ctrl (input addr, wdata, start_read, start_write, stop,
                 output rdata, data_ready, data_req, busy);

endinterface

// ==== run.sh ====
#!/bin/sh
# Build and run the QSPI subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ns \
   --top-module tb_qspi -f list.f -o tb_qspi_sim
./obj_dir/tb_qspi_sim

// ==== tb_qspi.sv ====
/* Testbench top for the QSPI memory subsystem with clock, reset,
   Wishbone master tasks, value checks and directed tests */
`timescale 1ns/1ns

module tb_qspi
   import qspi_pkg::*;
();

   logic                 clk;
   logic                 rstn;
   logic                 wb_cyc;
   logic                 wb_stb;
   logic                 wb_we;
   logic [addr_bits-1:0] wb_adr;
   logic [31:0]          wb_dat_w;
   logic [31:0]          wb_dat_r;
   logic                 wb_ack;
   logic [3:0]           spi_data_in;
   logic [3:0]           spi_data_out;
   logic [3:0]           spi_data_oe;
   logic                 spi_clk_out;
   logic                 spi_flash_select;
   logic                 spi_ram_a_select;
   logic                 spi_ram_b_select;
   int                   cmd_errors;
   logic [31:0]          ram_a_word;

   qspi_subsys DUT (.*);

   tb_qspi_mem u_mem (
      .rstn             (rstn),
      .spi_clk_out      (spi_clk_out),
      .spi_data_out     (spi_data_out),
      .spi_flash_select (spi_flash_select),
      .spi_ram_a_select (spi_ram_a_select),
      .spi_ram_b_select (spi_ram_b_select),
      .spi_data_in      (spi_data_in),
      .cmd_errors       (cmd_errors)
   );

   bind qspi_subsys tb_qspi_assert u_assert (
      .clk              (clk),
      .rstn             (rstn),
      .wb_cyc           (wb_cyc),
      .wb_stb           (wb_stb),
      .wb_ack           (wb_ack),
      .spi_data_oe      (spi_data_oe),
      .spi_flash_select (spi_flash_select),
      .spi_ram_a_select (spi_ram_a_select),
      .spi_ram_b_select (spi_ram_b_select)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic check_eq(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
      if (got !== exp) begin
         $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
         $display("tests failed");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic report_timeout(input string what);
      $display("Timeout: %s", what);
      $display("tests failed");
      $fatal(1, "timeout");
   endtask

   // Flash byte rule is address times 7 plus 3, words little endian
   function automatic logic [31:0] flash_word(input logic [addr_bits-1:0] adr);
      logic [31:0] w;
      for (int i = 0; i < 4; i++) begin
         w[8*i +: 8] = 8'((int'(adr) + i) * 7 + 3);
      end
      return w;
   endfunction

   task automatic wait_ack(output int cycles);
      cycles = 0;
      while (!wb_ack) begin
         if (cycles == 500) begin
            report_timeout("no wb_ack within 500 cycles");
         end
         @(posedge clk);
         #1;
         cycles++;
      end
   endtask

   task automatic wb_write(input logic [addr_bits-1:0] adr, input logic [31:0] data,
                           output int latency);
      @(posedge clk);
      #1;
      wb_cyc = 1'b1;
      wb_stb = 1'b1;
      wb_we = 1'b1;
      wb_adr = adr;
      wb_dat_w = data;
      wait_ack(latency);
      @(posedge clk);
      #1;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we = 1'b0;
   endtask

   task automatic wb_read(input logic [addr_bits-1:0] adr, output logic [31:0] data);
      int latency;
      @(posedge clk);
      #1;
      wb_cyc = 1'b1;
      wb_stb = 1'b1;
      wb_we = 1'b0;
      wb_adr = adr;
      wait_ack(latency);
      data = wb_dat_r;
      @(posedge clk);
      #1;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
   endtask

   task automatic flash_read_pattern();
      logic [addr_bits-1:0] adrs [4];
      logic [31:0]          got;
      adrs = '{25'h00, 25'h04, 25'h20, 25'h3C};
      foreach (adrs[i]) begin
         wb_read(adrs[i], got);
         check_eq("wb_dat_r", got, flash_word(adrs[i]));
      end
   endtask

   // RAM A and RAM B at the same offset hold separate words
   task automatic ram_isolation();
      logic [31:0] ram_b_word;
      logic [31:0] got;
      int          latency;
      ram_b_word = $urandom;
      ram_a_word = $urandom;
      wb_write(ram_b_base + 25'h8, ram_b_word, latency);
      wb_write(ram_a_base + 25'h8, ram_a_word, latency);
      wb_read(ram_a_base + 25'h8, got);
      check_eq("wb_dat_r", got, ram_a_word);
      wb_read(ram_b_base + 25'h8, got);
      check_eq("wb_dat_r", got, ram_b_word);
   endtask

   task automatic flash_write_dropped();
      logic [31:0] got;
      int          latency;
      wb_write(25'h10, 32'hDEAD_BEEF, latency);
      check_eq("wb_ack latency", 32'(latency), 32'd1);
      wb_read(25'h10, got);
      check_eq("wb_dat_r", got, flash_word(25'h10));
   endtask

   task automatic ram_back_to_back();
      logic [31:0] first;
      logic [31:0] second;
      logic [31:0] got;
      int          latency;
      first = $urandom;
      second = $urandom;
      wb_write(ram_a_base + 25'h10, first, latency);
      wb_write(ram_a_base + 25'h14, second, latency);
      wb_read(ram_a_base + 25'h10, got);
      check_eq("wb_dat_r", got, first);
      wb_read(ram_a_base + 25'h14, got);
      check_eq("wb_dat_r", got, second);
   endtask

   task automatic read_abort();
      logic [31:0] got;
      int          cycles;
      @(posedge clk);
      #1;
      wb_cyc = 1'b1;
      wb_stb = 1'b1;
      wb_we = 1'b0;
      wb_adr = ram_a_base + 25'h8;
      cycles = 0;
      while (spi_ram_a_select) begin
         if (cycles == 500) begin
            report_timeout("RAM A select never went low");
         end
         @(posedge clk);
         #1;
         cycles++;
      end
      // Drop the cycle partway through the command phase
      repeat (6) @(posedge clk);
      #1;
      check_eq("wb_ack", 32'(wb_ack), 32'd0);
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      cycles = 0;
      while (!(spi_flash_select && spi_ram_a_select && spi_ram_b_select)) begin
         if (cycles == 500) begin
            report_timeout("QSPI selects stayed low after wb_cyc dropped");
         end
         @(posedge clk);
         #1;
         cycles++;
      end
      wb_read(ram_a_base + 25'h8, got);
      check_eq("wb_dat_r", got, ram_a_word);
   endtask

   initial begin
      logic [31:0] seed;
      rstn = 1'b0;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we = 1'b0;
      wb_adr = '0;
      wb_dat_w = '0;
      ram_a_word = '0;
      seed = $urandom(13);
      repeat (2) @(posedge clk);
      #1;
      rstn = 1'b1;
      flash_read_pattern();
      ram_isolation();
      flash_write_dropped();
      ram_back_to_back();
      read_abort();
      check_eq("cmd_errors", 32'(cmd_errors), 32'd0);
      $display("all tests passed");
      $finish;
   end

endmodule

// ==== tb_qspi_assert.sv ====
/* Concurrent checks on the QSPI selects, output enables, RAM reselect
   spacing and the Wishbone acknowledge */
`timescale 1ns/1ns

module tb_qspi_assert
   import qspi_pkg::*;
(
   input logic       clk,
   input logic       rstn,
   input logic       wb_cyc,
   input logic       wb_stb,
   input logic       wb_ack,
   input logic [3:0] spi_data_oe,
   input logic       spi_flash_select,
   input logic       spi_ram_a_select,
   input logic       spi_ram_b_select
);

   logic all_high;

   assign all_high = spi_flash_select && spi_ram_a_select && spi_ram_b_select;

   one_select: assert property (@(posedge clk) disable iff (!rstn)
      $onehot0({!spi_flash_select, !spi_ram_a_select, !spi_ram_b_select}))
      else $error("more than one QSPI select low");

   idle_no_drive: assert property (@(posedge clk) disable iff (!rstn)
      all_high |-> spi_data_oe == 4'b0000)
      else $error("QSPI data driven with no device selected");

   ack_in_cycle: assert property (@(posedge clk) disable iff (!rstn)
      wb_ack |-> wb_cyc && wb_stb)
      else $error("wb_ack high outside an active bus cycle");

   // Same RAM selected again only after the minimum gap
   ram_a_gap: assert property (@(posedge clk) disable iff (!rstn)
      $fell(spi_ram_a_select) |-> $past(spi_ram_a_select, reselect_gap))
      else $error("RAM A reselected too early");

   ram_b_gap: assert property (@(posedge clk) disable iff (!rstn)
      $fell(spi_ram_b_select) |-> $past(spi_ram_b_select, reselect_gap))
      else $error("RAM B reselected too early");

endmodule

// ==== tb_qspi_mem.sv ====
/* Behavioral QSPI flash and two QSPI RAMs sharing one four-bit bus,
   decoding quad read and quad write commands */
`timescale 1ns/1ns

module tb_qspi_mem
   import qspi_pkg::*;
(
   input  logic       rstn,
   input  logic       spi_clk_out,
   input  logic [3:0] spi_data_out,
   input  logic       spi_flash_select,
   input  logic       spi_ram_a_select,
   input  logic       spi_ram_b_select,
   output logic [3:0] spi_data_in,
   output int         cmd_errors
);

   logic [7:0]               flash [64];
   logic [7:0]               ram_a [64];
   logic [7:0]               ram_b [64];
   logic [7:0]               cmd;
   logic [dev_addr_bits-1:0] addr;
   logic [3:0]               rd_nib;
   logic [3:0]               wr_hi;
   logic                     is_write;
   logic                     active;
   int                       rise_cnt;
   int                       nib_cnt;

   assign active = !(spi_flash_select && spi_ram_a_select && spi_ram_b_select);

   // Zero on the pins during reset gives a read delay setting of 0
   assign spi_data_in = rstn ? rd_nib : 4'h0;

   initial begin
      int         k;
      logic [5:0] idx;
      logic [7:0] rd_byte;
      cmd_errors = 0;
      rd_nib = 4'h0;
      for (int i = 0; i < 64; i++) begin
         flash[i] = 8'(i * 7 + 3);
         ram_a[i] = 8'h00;
         ram_b[i] = 8'h00;
      end
      forever begin
         @(posedge active);
         #1;
         rise_cnt = 0;
         nib_cnt = 0;
         is_write = 1'b0;
         while (active) begin
            // Look 1 ns after each edge so the pins have settled
            @(spi_clk_out or active);
            #1;
            if (active && spi_clk_out) begin
               if (rise_cnt < 8) begin
                  cmd = {cmd[6:0], spi_data_out[0]};
               end else if (rise_cnt < 8 + dev_addr_bits / 4) begin
                  if (rise_cnt == 8) begin
                     is_write = cmd == cmd_quad_write;
                     if (cmd != cmd_quad_read && cmd != cmd_quad_write) begin
                        cmd_errors++;
                     end
                     // Flash is read only
                     if (is_write && !spi_flash_select) begin
                        cmd_errors++;
                     end
                  end
                  addr = {addr[dev_addr_bits-5:0], spi_data_out};
               end else if (is_write) begin
                  k = rise_cnt - 8 - dev_addr_bits / 4;
                  idx = addr[5:0] + 6'(k / 2);
                  if (k % 2 == 0) begin
                     wr_hi = spi_data_out;
                  end else if (!spi_ram_a_select) begin
                     ram_a[idx] = {wr_hi, spi_data_out};
                  end else begin
                     ram_b[idx] = {wr_hi, spi_data_out};
                  end
               end
               rise_cnt++;
            end else if (active && !is_write &&
                         rise_cnt >= 8 + dev_addr_bits / 4 + dummy_nibbles_read) begin
               // Read data goes out on the falling clock, high nibble first
               k = nib_cnt;
               nib_cnt++;
               idx = addr[5:0] + 6'(k / 2);
               if (!spi_flash_select) begin
                  rd_byte = flash[idx];
               end else if (!spi_ram_a_select) begin
                  rd_byte = ram_a[idx];
               end else begin
                  rd_byte = ram_b[idx];
               end
               rd_nib = (k % 2 == 0) ? rd_byte[7:4] : rd_byte[3:0];
            end
         end
         rd_nib = 4'h0;
      end
   end

endmodule

// ==== wb_qspi_bridge.sv ====
/* Wishbone classic slave turning word accesses into four-byte QSPI
   bursts sent least significant byte first */
`timescale 1ns/1ns

module wb_qspi_bridge
   import qspi_pkg::*;
(
   input  logic                            clk,
   input  logic                            rstn,
   input  logic                            wb_cyc,
   input  logic                            wb_stb,
   input  logic                            wb_we,
   input  logic [addr_bits-1:0]            wb_adr,
   input  logic [word_bytes*byte_bits-1:0] wb_dat_w,
   output logic [word_bytes*byte_bits-1:0] wb_dat_r,
   output logic                            wb_ack,
   qspi_txn_if.host                        txn
);

   typedef enum logic [1:0] {
      st_idle,
      st_start,
      st_xfer,
      st_finish
   } state_t;

   state_t                          state;
   logic [1:0]                      byte_cnt;
   logic [word_bytes*byte_bits-1:0] word;
   logic                            start_sent;
   logic                            byte_done;
   logic                            abort;

   assign txn.addr  = wb_adr;
   assign txn.wdata = word[byte_bits-1:0];

   // Start repeats until the controller accepts it
   assign txn.start_read  = (state == st_start) && wb_cyc && !wb_we && !txn.busy;
   assign txn.start_write = (state == st_start) && wb_cyc && wb_we && !txn.busy;

   // Master gave up the cycle before the word was done
   assign abort    = !wb_cyc && (state == st_start || state == st_xfer);
   assign txn.stop = (state == st_finish) || abort;

   assign byte_done = wb_we ? txn.data_req : txn.data_ready;
   assign wb_dat_r  = word;
   assign wb_ack    = state == st_finish;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state      <= st_idle;
         byte_cnt   <= 2'd0;
         start_sent <= 1'b0;
      end else begin
         start_sent <= txn.start_read || txn.start_write;
         case (state)
            st_idle: begin
               byte_cnt <= 2'd0;
               if (wb_cyc && wb_stb) begin
                  // Flash writes are acknowledged and dropped
                  state <= (wb_we && wb_adr < ram_a_base) ? st_finish : st_start;
               end
            end
            st_start: begin
               if (!wb_cyc) begin
                  state <= st_idle;
               end else if (start_sent && txn.busy) begin
                  state <= st_xfer;
               end
            end
            st_xfer: begin
               if (!wb_cyc) begin
                  state <= st_idle;
               end else if (byte_done) begin
                  byte_cnt <= byte_cnt + 2'd1;
                  if (byte_cnt == 2'(word_bytes - 1)) begin
                     state <= st_finish;
                  end
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   // Read bytes enter at the top and write bytes leave at the bottom
   always_ff @(posedge clk) begin
      if (state == st_idle) begin
         word <= wb_dat_w;
      end else if (state == st_xfer && byte_done) begin
         word <= {txn.rdata, word[word_bytes*byte_bits-1:byte_bits]};
      end
   end

endmodule
